// ==== common/ws2812_pkg.sv ====
// Shared register map, status bits and field widths for the WS2812B receiver and its testbench
package ws2812_pkg;

    // ----------------------------------------
    // Field widths
    // ----------------------------------------
    localparam int PIXEL_BITS = 24;   // Bits kept from each frame
    localparam int COLOR_W    = 8;    // One colour channel
    localparam int APB_ADDR_W = 12;   // APB byte address
    localparam int APB_DATA_W = 32;   // APB data bus

    // ----------------------------------------
    // Register offsets
    // ----------------------------------------
    // Red, green and blue are laid out in RGB order on the bus,
    // the line itself carries them as G, R, B
    localparam logic [APB_ADDR_W-1:0] ADDR_RED    = 12'h000;  // Red byte
    localparam logic [APB_ADDR_W-1:0] ADDR_GREEN  = 12'h004;  // Green byte
    localparam logic [APB_ADDR_W-1:0] ADDR_BLUE   = 12'h008;  // Blue byte
    localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 12'h00C;  // Flags, write bit 0 to clear
    localparam logic [APB_ADDR_W-1:0] ADDR_FRAMES = 12'h010;  // Wrapping frame count

    // ----------------------------------------
    // Status bit positions
    // ----------------------------------------
    localparam int STAT_READY   = 0;  // Pixel captured since last clear
    localparam int STAT_OVERRUN = 1;  // Pixel captured while ready still set

endpackage

// ==== rx_frontend/ws2812_line_decoder.sv ====
// Line decoder that times high pulses on the LED line into bits and flags the end of a frame
module ws2812_line_decoder #(
    parameter int CLK_HZ       = 125_000_000,  // System clock in Hz
    parameter int THRESHOLD_NS = 600,          // High time above this decodes as 1
    parameter int IDLE_US      = 10            // Low time that closes a frame
) (
    input  logic clk,
    input  logic reset,
    input  logic din,        // LED data line, already in the clk domain
    output logic bit_valid,  // One-cycle pulse per decoded bit
    output logic bit_value,  // Decoded bit, valid with bit_valid
    output logic frame_end   // One-cycle pulse per idle gap
);

    // ----------------------------------------
    // Cycle counts from the timing parameters
    // ----------------------------------------
    // 64-bit products, CLK_HZ * THRESHOLD_NS easily passes 2^31
    localparam longint THRESH_L = (longint'(CLK_HZ) * longint'(THRESHOLD_NS)) / 1_000_000_000;
    localparam longint IDLE_L   = (longint'(CLK_HZ) * longint'(IDLE_US)) / 1_000_000;

    localparam int THRESH_CYCLES = int'(THRESH_L);
    localparam int IDLE_CYCLES   = int'(IDLE_L);
    localparam int HIGH_MAX      = THRESH_CYCLES + 1;   // Past threshold is all we need to know
    localparam int HIGH_W        = $clog2(HIGH_MAX + 1);
    localparam int LOW_W         = $clog2(IDLE_CYCLES + 1);

    logic              din_q;     // Previous line sample
    logic [HIGH_W-1:0] high_cnt;  // High samples in current run
    logic [LOW_W-1:0]  low_cnt;   // Low samples before current one
    logic              armed;     // A high was seen since the last frame_end
    logic              fall;      // First low sample after a high run
    logic              idle_hit;  // Low run just reached the idle count

    assign fall     = din_q & ~din;
    assign idle_hit = armed & ~din & (low_cnt == LOW_W'(IDLE_CYCLES - 1));

    // Previous sample for edge detection
    always_ff @(posedge clk) begin
        if (reset) begin
            din_q <= 1'b0;
        end else begin
            din_q <= din;
        end
    end

    // ----------------------------------------
    // High time, saturating
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            high_cnt <= '0;
        end else if (din) begin
            if (high_cnt != HIGH_W'(HIGH_MAX)) begin
                high_cnt <= high_cnt + 1'b1;
            end
        end else begin
            high_cnt <= '0;  // Restart for the next pulse
        end
    end

    // One bit per falling edge, counter still holds the full run here
    always_ff @(posedge clk) begin
        if (reset) begin
            bit_valid <= 1'b0;
            bit_value <= 1'b0;
        end else begin
            bit_valid <= fall;
            if (fall) begin
                bit_value <= (high_cnt > HIGH_W'(THRESH_CYCLES));  // Long pulse is a 1
            end
        end
    end

    // ----------------------------------------
    // Low time and end of frame
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            low_cnt <= '0;
        end else if (din) begin
            low_cnt <= '0;
        end else if (low_cnt != LOW_W'(IDLE_CYCLES)) begin
            low_cnt <= low_cnt + 1'b1;  // Holds at the idle count
        end
    end

    // Single pulse per gap, re-armed by any high sample
    always_ff @(posedge clk) begin
        if (reset) begin
            armed     <= 1'b0;
            frame_end <= 1'b0;
        end else begin
            frame_end <= idle_hit;
            if (din) begin
                armed <= 1'b1;
            end else if (idle_hit) begin
                armed <= 1'b0;
            end
        end
    end

endmodule

// ==== rx_frontend/ws2812_pixel_capture.sv ====
// Pixel capture that assembles the first 24 bits of a frame into colours and forwards the rest
module ws2812_pixel_capture
    import ws2812_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               din,         // Raw line, source for forwarding
    input  logic               bit_valid,   // Decoded bit strobe
    input  logic               bit_value,   // Decoded bit
    input  logic               frame_end,   // Idle gap seen
    output logic [COLOR_W-1:0] red,
    output logic [COLOR_W-1:0] green,
    output logic [COLOR_W-1:0] blue,
    output logic               pixel_done,  // One-cycle pulse per captured pixel
    output logic               dout         // Forwarded line
);

    // ----------------------------------------
    // Bit counting and shifting
    // ----------------------------------------
    logic [4:0]            bit_cnt;     // Bits taken in this frame
    logic [PIXEL_BITS-2:0] shift_q;     // First 23 bits, MSB first
    logic [PIXEL_BITS-1:0] pixel_word;  // Full word once the last bit arrives
    logic                  passthru;    // Own pixel done, line goes downstream
    logic                  take_bit;    // Bit belongs to this pixel
    logic                  last_bit;    // Bit 24 of the frame
    logic                  din_q;       // One-cycle delayed line

    assign take_bit   = bit_valid & ~passthru;
    assign last_bit   = take_bit & (bit_cnt == 5'(PIXEL_BITS - 1));
    assign pixel_word = {shift_q, bit_value};  // Last bit joins directly

    // Shift register, data only
    always_ff @(posedge clk) begin
        if (take_bit) begin
            shift_q <= pixel_word[PIXEL_BITS-2:0];
        end
    end

    // Counter and passthrough flag
    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt  <= '0;
            passthru <= 1'b0;
        end else if (frame_end) begin
            bit_cnt  <= '0;    // Next frame starts at bit 1
            passthru <= 1'b0;
        end else if (take_bit) begin
            bit_cnt <= bit_cnt + 1'b1;  // Stops at 24, later bits not counted
            if (last_bit) begin
                passthru <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Colour latch, wire order is G R B
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            red        <= '0;
            green      <= '0;
            blue       <= '0;
            pixel_done <= 1'b0;
        end else begin
            pixel_done <= last_bit;
            if (last_bit) begin
                green <= pixel_word[23:16];  // First byte on the wire
                red   <= pixel_word[15:8];
                blue  <= pixel_word[7:0];
            end
        end
    end

    // ----------------------------------------
    // Forwarding
    // ----------------------------------------
    always_ff @(posedge clk) begin
        din_q <= din;  // Line copy, gated below
    end

    // Low unless the pixel for this LED is already taken
    assign dout = passthru & din_q;

endmodule

// ==== verilog/ws2812_apb_regs.sv ====
// APB register block with status flags, frame counter and colour readback for the receiver
module ws2812_apb_regs
    import ws2812_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    // APB slave
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [APB_DATA_W-1:0] pwdata,
    output logic [APB_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    // From pixel capture and decoder
    input  logic [COLOR_W-1:0]    red,
    input  logic [COLOR_W-1:0]    green,
    input  logic [COLOR_W-1:0]    blue,
    input  logic                  pixel_done,
    input  logic                  frame_end
);

    localparam int PAD_W = APB_DATA_W - COLOR_W;  // Zero fill above a byte

    logic                  ready_flag;    // STAT_READY
    logic                  overrun_flag;  // STAT_OVERRUN
    logic [7:0]            frame_cnt;     // Wraps at 256
    logic                  access;        // APB access phase
    logic                  addr_ok;       // One of the five offsets
    logic                  clear_req;     // Status clear write
    logic [APB_DATA_W-1:0] status_word;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    assign access = psel & penable;
    assign pready = 1'b1;  // No wait states

    assign addr_ok = (paddr == ADDR_RED)    || (paddr == ADDR_GREEN) ||
                     (paddr == ADDR_BLUE)   || (paddr == ADDR_STATUS) ||
                     (paddr == ADDR_FRAMES);

    assign pslverr   = access & ~addr_ok;
    assign clear_req = access & pwrite & (paddr == ADDR_STATUS) & pwdata[0];

    always_comb begin
        status_word               = '0;
        status_word[STAT_READY]   = ready_flag;
        status_word[STAT_OVERRUN] = overrun_flag;
    end

    // Read mux, unmapped returns zero
    always_comb begin
        case (paddr)
            ADDR_RED:    prdata = {{PAD_W{1'b0}}, red};
            ADDR_GREEN:  prdata = {{PAD_W{1'b0}}, green};
            ADDR_BLUE:   prdata = {{PAD_W{1'b0}}, blue};
            ADDR_STATUS: prdata = status_word;
            ADDR_FRAMES: prdata = {{(APB_DATA_W - 8){1'b0}}, frame_cnt};
            default:     prdata = '0;
        endcase
    end

    // ----------------------------------------
    // Status flags
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ready_flag   <= 1'b0;
            overrun_flag <= 1'b0;
        end else if (pixel_done) begin
            // New pixel wins over a clear in the same cycle
            ready_flag   <= 1'b1;
            overrun_flag <= overrun_flag | ready_flag;  // Previous pixel never cleared
        end else if (clear_req) begin
            ready_flag   <= 1'b0;
            overrun_flag <= 1'b0;
        end
    end

    // Frame counter
    always_ff @(posedge clk) begin
        if (reset) begin
            frame_cnt <= '0;
        end else if (frame_end) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

endmodule

// ==== verilog/ws2812_receiver_top.sv ====
// Top level of the WS2812B receive peripheral, ties line decoder, pixel capture and APB registers
module ws2812_receiver_top
    import ws2812_pkg::*;
#(
    parameter int CLK_HZ       = 125_000_000,  // System clock in Hz
    parameter int THRESHOLD_NS = 600,          // 0/1 boundary on high time
    parameter int IDLE_US      = 10            // Frame gap
) (
    input  logic                  clk,
    input  logic                  reset,
    // LED chain
    input  logic                  din,      // From upstream
    output logic                  dout,     // To downstream LEDs
    // APB slave
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [APB_DATA_W-1:0] pwdata,
    output logic [APB_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr
);

    // ----------------------------------------
    // Internal wiring
    // ----------------------------------------
    logic               bit_valid;
    logic               bit_value;
    logic               frame_end;   // Shared by capture and registers
    logic [COLOR_W-1:0] red;
    logic [COLOR_W-1:0] green;
    logic [COLOR_W-1:0] blue;
    logic               pixel_done;

    // Timing lives only in the decoder
    ws2812_line_decoder #(
        .CLK_HZ       (CLK_HZ),
        .THRESHOLD_NS (THRESHOLD_NS),
        .IDLE_US      (IDLE_US)
    ) line_decoder_inst (
        .clk       (clk),
        .reset     (reset),
        .din       (din),
        .bit_valid (bit_valid),
        .bit_value (bit_value),
        .frame_end (frame_end)
    );

    ws2812_pixel_capture pixel_capture_inst (
        .clk        (clk),
        .reset      (reset),
        .din        (din),
        .bit_valid  (bit_valid),
        .bit_value  (bit_value),
        .frame_end  (frame_end),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .pixel_done (pixel_done),
        .dout       (dout)
    );

    ws2812_apb_regs apb_regs_inst (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .pixel_done (pixel_done),
        .frame_end  (frame_end)
    );

endmodule

// ==== testbench/ws2812_tb_tasks.svh ====
// Tasks included by the testbench top for APB access, line stimulus and the directed tests
`ifndef WS2812_TB_TASKS_SVH
`define WS2812_TB_TASKS_SVH

// ----------------------------------------
// APB access without wait states
// ----------------------------------------
task automatic read_reg(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data,
                        output logic err);
    @(posedge clk);
    #1 psel = 1'b1;  // Setup
    pwrite = 1'b0;
    paddr  = addr;
    @(posedge clk);
    #1 penable = 1'b1;
    @(negedge clk);  // Mid access cycle
    data = prdata;
    err  = pslverr;
    check_value("pready", 32'h1, {31'h0, pready});
    @(posedge clk);
    #1 psel = 1'b0;
    penable = 1'b0;
endtask

task automatic write_reg(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
    @(posedge clk);
    #1 psel = 1'b1;
    pwrite = 1'b1;
    paddr  = addr;
    pwdata = data;
    @(posedge clk);
    #1 penable = 1'b1;
    @(negedge clk);  // Mid access cycle
    check_value("pready", 32'h1, {31'h0, pready});
    @(posedge clk);  // Write lands on this edge
    #1 psel = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

// Read a mapped register and expect a clean response
task automatic expect_reg(input string name, input logic [APB_ADDR_W-1:0] addr,
                          input logic [31:0] expected);
    logic [31:0] data;
    logic        err;
    read_reg(addr, data, err);
    check_value(name, expected, data);
    check_value({name, " pslverr"}, 32'h0, {31'h0, err});
endtask

// ----------------------------------------
// Line stimulus
// ----------------------------------------
task automatic drive_line(input logic level, input int cycles);
    @(posedge clk);
    #1 din = level;
    repeat (cycles - 1) @(posedge clk);
endtask

task automatic send_bits(input logic [23:0] word, input int count);
    int i;
    for (i = count - 1; i >= 0; i--) begin  // MSB first
        drive_line(1'b1, word[i] ? ONE_HIGH : ZERO_HIGH);
        drive_line(1'b0, word[i] ? ONE_LOW : ZERO_LOW);
    end
endtask

task automatic end_frame();
    drive_line(1'b0, FRAME_GAP);
    frames_sent++;
endtask

function automatic logic [23:0] random_pixel();
    return 24'($random(seed));
endfunction

// Colours of a G R B word as the registers show them
task automatic expect_colours(input logic [23:0] pixel);
    expect_reg("red", ADDR_RED, {24'h0, pixel[15:8]});
    expect_reg("green", ADDR_GREEN, {24'h0, pixel[23:16]});
    expect_reg("blue", ADDR_BLUE, {24'h0, pixel[7:0]});
endtask

// ----------------------------------------
// Directed tests
// ----------------------------------------
task automatic check_reset_state();
    int start_errors;
    start_errors = error_count;
    expect_colours(24'h0);
    expect_reg("status", ADDR_STATUS, 32'h0);
    expect_reg("frames", ADDR_FRAMES, 32'h0);
    check_value("dout", 32'h0, {31'h0, dout});
    check_true(dout_high_count == 0, "dout went high after reset");
    finish_test("reset state", start_errors);
endtask

task automatic capture_single_pixel();
    int          start_errors;
    logic [23:0] pixel;
    start_errors = error_count;
    pixel = random_pixel();
    send_bits(pixel, 24);
    end_frame();
    expect_colours(pixel);
    expect_reg("status", ADDR_STATUS, 32'h1 << STAT_READY);
    finish_test("single pixel capture", start_errors);
endtask

task automatic forward_second_pixel();
    int          start_errors;
    int          high_before;
    int          i;
    logic [23:0] first;
    logic [23:0] second;
    start_errors = error_count;
    first  = random_pixel();
    second = random_pixel();
    mon_bits.delete();
    high_before = dout_high_count;
    send_bits(first, 24);
    check_true(dout_high_count == high_before, "dout went high during the first 24 bits");
    send_bits(second, 24);
    end_frame();
    expect_colours(first);
    check_value("forwarded bit count", 32'd24, mon_bits.size());
    for (i = 0; i < 24 && i < mon_bits.size(); i++) begin
        check_value($sformatf("dout bit %0d", i), {31'h0, second[23-i]}, {31'h0, mon_bits[i]});
    end
    finish_test("forwarding", start_errors);
endtask

task automatic overrun_and_clear();
    int          start_errors;
    logic [23:0] first;
    logic [23:0] second;
    start_errors = error_count;
    write_reg(ADDR_STATUS, 32'h1);
    expect_reg("status", ADDR_STATUS, 32'h0);
    first  = random_pixel();
    second = random_pixel();
    send_bits(first, 24);
    end_frame();
    send_bits(second, 24);
    end_frame();
    expect_reg("status", ADDR_STATUS, (32'h1 << STAT_READY) | (32'h1 << STAT_OVERRUN));
    expect_colours(second);
    write_reg(ADDR_STATUS, 32'h1);
    expect_reg("status", ADDR_STATUS, 32'h0);
    finish_test("overrun and clear", start_errors);
endtask

task automatic count_frames_and_errors();
    int          start_errors;
    logic [31:0] data;
    logic        err;
    start_errors = error_count;
    repeat (COUNT_FRAMES) begin
        send_bits(random_pixel(), 24);
        end_frame();
    end
    expect_reg("frames", ADDR_FRAMES, 32'(frames_sent % 256));
    read_reg(12'h014, data, err);  // First unmapped offset
    check_value("prdata", 32'h0, data);
    check_value("pslverr", 32'h1, {31'h0, err});
    finish_test("frame counter and error", start_errors);
endtask

`endif

// ==== testbench/ws2812_tb.sv ====
// Testbench top for the WS2812B receiver that is run as top module ws2812_tb from the file list
module ws2812_tb
    import ws2812_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // ----------------------------------------
    // Timing of the DUT and of the line
    // ----------------------------------------
    localparam int CLK_HZ       = 125_000_000;
    localparam int THRESHOLD_NS = 600;
    localparam int IDLE_US      = 10;
    localparam int CLK_PERIOD   = 8;                                      // ns
    localparam int THRESH_CYCLES = (CLK_HZ / 1_000_000) * THRESHOLD_NS / 1000;  // 75 cycles

    localparam int ZERO_HIGH = 40;    // Short pulse
    localparam int ZERO_LOW  = 85;
    localparam int ONE_HIGH  = 100;   // Long pulse
    localparam int ONE_LOW   = 45;
    localparam int FRAME_GAP = 1400;  // Longer than the idle limit
    localparam int BIT_MAX   = ONE_HIGH + ONE_LOW;

    // Frames sent by the single, forward, overrun and counter tests
    localparam int COUNT_FRAMES = 3;
    localparam int TOTAL_FRAMES = 1 + 1 + 2 + COUNT_FRAMES;
    localparam int TOTAL_BITS   = PIXEL_BITS * (1 + 2 + 2 + COUNT_FRAMES);
    localparam int TIMEOUT_NS   =
        (TOTAL_BITS * BIT_MAX + TOTAL_FRAMES * FRAME_GAP) * 12 / 10 * CLK_PERIOD;

    logic                  clk;
    logic                  reset;
    logic                  din;
    logic                  dout;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    integer seed            = 35128;
    int     error_count     = 0;
    int     check_count     = 0;
    int     test_count      = 0;
    int     failed_tests    = 0;
    int     frames_sent     = 0;  // Frames since reset
    int     dout_high_count = 0;  // Cycles with dout high
    int     mon_high        = 0;  // Current dout high run
    bit     mon_bits[$];          // Bits decoded from dout

    ws2812_receiver_top #(
        .CLK_HZ       (CLK_HZ),
        .THRESHOLD_NS (THRESHOLD_NS),
        .IDLE_US      (IDLE_US)
    ) ws2812_receiver_top_inst (
        .clk     (clk),
        .reset   (reset),
        .din     (din),
        .dout    (dout),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Line monitor using the decoder's width rule, sampled mid cycle
    always @(negedge clk) begin
        if (reset) begin
            mon_high = 0;
        end else if (dout) begin
            mon_high        = mon_high + 1;
            dout_high_count = dout_high_count + 1;
        end else if (mon_high != 0) begin
            mon_bits.push_back(mon_high > THRESH_CYCLES);  // Long run is a 1
            mon_high = 0;
        end
    end

    // Check helpers
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("Mismatch %s: expected 0x%0h, got 0x%0h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        check_count++;
        assert (cond) else begin
            $display("Error: %s", what);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        test_count++;
        if (error_count == start_errors) begin
            $display("%-26s PASS", name);
        end else begin
            $display("%-26s FAIL with %0d errors", name, error_count - start_errors);
            failed_tests++;
        end
    endtask

    `include "ws2812_tb_tasks.svh"

    // Watchdog sized from the frames sent by all tests
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the test sequence did not finish within %0d ns", TIMEOUT_NS);
        $display("tests failed");
        $finish;
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        din     = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        reset   = 1'b1;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;

        check_reset_state();
        capture_single_pixel();
        forward_second_pixel();
        overrun_and_clear();
        count_frames_and_errors();

        $display("Summary: %0d tests, %0d failing, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+testbench
common/ws2812_pkg.sv
rx_frontend/ws2812_line_decoder.sv
rx_frontend/ws2812_pixel_capture.sv
verilog/ws2812_apb_regs.sv
verilog/ws2812_receiver_top.sv
testbench/ws2812_tb.sv

// ==== Bender.yml ====
package:
  name: ws2812_receiver

sources:
  # RTL in compile order
  - common/ws2812_pkg.sv
  - rx_frontend/ws2812_line_decoder.sv
  - rx_frontend/ws2812_pixel_capture.sv
  - verilog/ws2812_apb_regs.sv
  - verilog/ws2812_receiver_top.sv

  # Testbench
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/ws2812_tb.sv
